//--- design/dcore_consts.svh
`ifndef DCORE_CONSTS_SVH
`define DCORE_CONSTS_SVH

// Lane count and sample widths
`define DCORE_NTI       4
`define DCORE_NADC      8

// Phase interpolator and loop filter
`define DCORE_NPI       9
`define DCORE_KI_MAX    15

// PRBS checker
`define DCORE_NPRBS     7
`define DCORE_NCNT      32

// APB bus
`define DCORE_AW        8
`define DCORE_DW        32

// Register word addresses
`define DCORE_ADDR_CTRL     8'h00
`define DCORE_ADDR_SEED     8'h04
`define DCORE_ADDR_OFFSET   8'h08
`define DCORE_ADDR_PI_EXT   8'h0C
`define DCORE_ADDR_PI_OFS   8'h10
`define DCORE_ADDR_GAIN     8'h14
`define DCORE_ADDR_SAMPLE   8'h18
`define DCORE_ADDR_CORRECT  8'h1C
`define DCORE_ADDR_TOTAL    8'h20
`define DCORE_ADDR_PI_CODE  8'h24

`endif

//--- design/dcore_pkg.sv
`include "dcore_consts.svh"

package dcore_pkg;

    // Checker operating mode
    typedef enum logic [1:0] {
        PRBS_HOLD = 2'd0,
        PRBS_LOAD = 2'd1,
        PRBS_RUN  = 2'd2
    } prbs_mode_e;

    // APB register map, read-only entries from REG_SAMPLE on
    typedef enum logic [`DCORE_AW-1:0] {
        REG_CTRL    = `DCORE_ADDR_CTRL,
        REG_SEED    = `DCORE_ADDR_SEED,
        REG_OFFSET  = `DCORE_ADDR_OFFSET,
        REG_PI_EXT  = `DCORE_ADDR_PI_EXT,
        REG_PI_OFS  = `DCORE_ADDR_PI_OFS,
        REG_GAIN    = `DCORE_ADDR_GAIN,
        REG_SAMPLE  = `DCORE_ADDR_SAMPLE,
        REG_CORRECT = `DCORE_ADDR_CORRECT,
        REG_TOTAL   = `DCORE_ADDR_TOTAL,
        REG_PI_CODE = `DCORE_ADDR_PI_CODE
    } reg_addr_e;

endpackage

//--- design/adc_unfold.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcore_consts.svh"

module adc_unfold (
    input  wire logic                                   clk_adc,
    input  wire logic                                   arst_n_i,
    input  wire logic [`DCORE_NTI-1:0][`DCORE_NADC-2:0] adc_mag_i,
    input  wire logic [`DCORE_NTI-1:0]                  adc_sign_i,
    input  wire logic [`DCORE_NTI-1:0][`DCORE_NADC-1:0] lane_offset_i,
    output logic      [`DCORE_NTI-1:0][`DCORE_NADC-1:0] samples_o
);

    localparam int SMAX = 2**(`DCORE_NADC-1) - 1;
    localparam int SMIN = -(2**(`DCORE_NADC-1));
    localparam logic [`DCORE_NADC-1:0] SAT_HI = {1'b0, {(`DCORE_NADC-1){1'b1}}};
    localparam logic [`DCORE_NADC-1:0] SAT_LO = {1'b1, {(`DCORE_NADC-1){1'b0}}};

    logic [`DCORE_NTI-1:0][`DCORE_NADC-2:0] mag_q;
    logic [`DCORE_NTI-1:0]                  sign_q;
    logic signed [`DCORE_NADC+1:0]          diff [`DCORE_NTI];

    // Retime stage
    always_ff @(posedge clk_adc or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mag_q  <= '0;
            sign_q <= '0;
        end else begin
            mag_q  <= adc_mag_i;
            sign_q <= adc_sign_i;
        end
    end

    // Apply sign and remove lane offset
    // Two guard bits keep the full range
    always_comb begin
        for (int k = 0; k < `DCORE_NTI; k++) begin
            diff[k] = (sign_q[k] ? $signed({3'b000, mag_q[k]})
                                 : -$signed({3'b000, mag_q[k]}))
                    - $signed({{2{lane_offset_i[k][`DCORE_NADC-1]}}, lane_offset_i[k]});
        end
    end

    // Unfold stage with clamp
    always_ff @(posedge clk_adc or negedge arst_n_i) begin
        if (!arst_n_i) begin
            samples_o <= '0;
        end else begin
            for (int k = 0; k < `DCORE_NTI; k++) begin
                if (diff[k] > SMAX) begin
                    samples_o[k] <= SAT_HI;
                end else if (diff[k] < SMIN) begin
                    samples_o[k] <= SAT_LO;
                end else begin
                    samples_o[k] <= diff[k][`DCORE_NADC-1:0];
                end
            end
        end
    end

    for (genvar k = 0; k < `DCORE_NTI; k++) begin : g_chk
        // Low rail needs a negative slice whose magnitude plus offset reaches 128
        a_min_only_at_rail: assert property (@(posedge clk_adc) disable iff (!arst_n_i)
            (samples_o[k] == SAT_LO) |->
                $past(!sign_q[k]
                      && int'(mag_q[k]) + int'($signed(lane_offset_i[k])) >= -SMIN));
    end

endmodule

`default_nettype wire

//--- design/mm_cdr.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcore_consts.svh"

module mm_cdr (
    input  wire logic                                   clk_adc,
    input  wire logic                                   arst_n_i,
    input  wire logic [`DCORE_NTI-1:0][`DCORE_NADC-1:0] samples_i,
    input  wire logic                                   pi_ext_sel_i,
    input  wire logic [`DCORE_NPI-1:0]                  pi_ext_i,
    input  wire logic [`DCORE_NPI-1:0]                  pi_ofs_i,
    input  wire logic [3:0]                             kp_shift_i,
    input  wire logic [3:0]                             ki_shift_i,
    output logic      [`DCORE_NPI-1:0]                  pi_ctl_o
);

    // Each term fits in NADC+2 bits and the four-lane sum needs two more
    localparam int SW = `DCORE_NADC + 4;

    logic [`DCORE_NADC-1:0]               last_q;
    logic [`DCORE_NTI:0][`DCORE_NADC-1:0] chain;
    logic signed [SW-1:0]                 prev_x [`DCORE_NTI];
    logic signed [SW-1:0]                 cur_x [`DCORE_NTI];
    logic signed [SW-1:0]                 term [`DCORE_NTI];
    logic signed [SW-1:0]                 pd_sum;
    logic signed [SW-1:0]                 prop_term;
    logic signed [SW-1:0]                 int_term;
    logic [`DCORE_NPI-1:0]                integ_q;
    logic [`DCORE_NPI-1:0]                loop_code;

    // Lane 0 pairs with the last lane of the previous cycle
    assign chain = {samples_i, last_q};

    // MM detector sgn(prev)*cur - prev*sgn(cur)
    always_comb begin
        pd_sum = '0;
        for (int k = 0; k < `DCORE_NTI; k++) begin
            prev_x[k] = SW'($signed(chain[k]));
            cur_x[k]  = SW'($signed(chain[k+1]));
            term[k]   = (prev_x[k][SW-1] ? -cur_x[k] : cur_x[k])
                      - (cur_x[k][SW-1] ? -prev_x[k] : prev_x[k]);
            pd_sum    = pd_sum + term[k];
        end
    end

    // Proportional and integral paths
    assign prop_term = pd_sum >>> kp_shift_i;
    assign int_term  = pd_sum >>> ki_shift_i;

    // code wraps modulo the PI range
    assign loop_code = integ_q + prop_term[`DCORE_NPI-1:0];

    always_ff @(posedge clk_adc or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_q   <= '0;
            integ_q  <= '0;
            pi_ctl_o <= '0;
        end else begin
            last_q <= samples_i[`DCORE_NTI-1];
            if (!pi_ext_sel_i) begin
                integ_q <= integ_q + int_term[`DCORE_NPI-1:0];
            end
            pi_ctl_o <= pi_ofs_i + (pi_ext_sel_i ? pi_ext_i : loop_code);
        end
    end

    a_ki_range: assert property (@(posedge clk_adc) disable iff (!arst_n_i)
        ki_shift_i <= `DCORE_KI_MAX);

endmodule

`default_nettype wire

//--- design/prbs_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcore_consts.svh"

module prbs_checker (
    input  wire logic                                   clk_adc,
    input  wire logic                                   arst_n_i,
    input  wire logic [`DCORE_NTI-1:0][`DCORE_NADC-1:0] samples_i,
    input  wire dcore_pkg::prbs_mode_e                  mode_i,
    input  wire logic [`DCORE_NPRBS-1:0]                seed_i,
    output logic      [`DCORE_NCNT-1:0]                 correct_cnt_o,
    output logic      [`DCORE_NCNT-1:0]                 total_cnt_o
);

    import dcore_pkg::*;

    localparam int MW = $clog2(`DCORE_NTI + 1);

    logic [`DCORE_NPRBS-1:0] gen_q;
    logic [`DCORE_NPRBS-1:0] gen_next;
    logic [`DCORE_NTI-1:0]   rx_bits;
    logic [`DCORE_NTI-1:0]   ref_bits;
    logic [MW-1:0]           match_cnt;

    // Decision is the inverted sample sign
    always_comb begin
        for (int k = 0; k < `DCORE_NTI; k++) begin
            rx_bits[k] = ~samples_i[k][`DCORE_NADC-1];
        end
    end

    // x^7+x^6+1, four steps per cycle, lane 0 first
    always_comb begin
        gen_next  = gen_q;
        match_cnt = '0;
        for (int k = 0; k < `DCORE_NTI; k++) begin
            ref_bits[k] = gen_next[`DCORE_NPRBS-1] ^ gen_next[`DCORE_NPRBS-2];
            gen_next    = {gen_next[`DCORE_NPRBS-2:0], ref_bits[k]};
            if (ref_bits[k] == rx_bits[k]) begin
                match_cnt = match_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_adc or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gen_q         <= '0;
            correct_cnt_o <= '0;
            total_cnt_o   <= '0;
        end else begin
            case (mode_i)
                PRBS_LOAD: begin
                    gen_q         <= seed_i;
                    correct_cnt_o <= '0;
                    total_cnt_o   <= '0;
                end
                PRBS_RUN: begin
                    gen_q         <= gen_next;
                    correct_cnt_o <= correct_cnt_o + match_cnt;
                    total_cnt_o   <= total_cnt_o + `DCORE_NTI;
                end
                // Hold and the unused code freeze everything
                default: ;
            endcase
        end
    end

    a_cnt_order: assert property (@(posedge clk_adc) disable iff (!arst_n_i)
        correct_cnt_o <= total_cnt_o);

endmodule

`default_nettype wire

//--- design/dcore_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcore_consts.svh"

module dcore_regs (
    input  wire logic                                   clk_adc,
    input  wire logic                                   arst_n_i,
    input  wire logic [`DCORE_AW-1:0]                   paddr_i,
    input  wire logic                                   psel_i,
    input  wire logic                                   penable_i,
    input  wire logic                                   pwrite_i,
    input  wire logic [`DCORE_DW-1:0]                   pwdata_i,
    output logic      [`DCORE_DW-1:0]                   prdata_o,
    output logic                                        pready_o,
    output logic                                        pslverr_o,
    output logic      [`DCORE_NTI-1:0][`DCORE_NADC-1:0] lane_offset_o,
    output dcore_pkg::prbs_mode_e                       prbs_mode_o,
    output logic      [`DCORE_NPRBS-1:0]                prbs_seed_o,
    output logic                                        pi_ext_sel_o,
    output logic      [`DCORE_NPI-1:0]                  pi_ext_o,
    output logic      [`DCORE_NPI-1:0]                  pi_ofs_o,
    output logic      [3:0]                             kp_shift_o,
    output logic      [3:0]                             ki_shift_o,
    input  wire logic [`DCORE_NTI-1:0][`DCORE_NADC-1:0] samples_i,
    input  wire logic [`DCORE_NCNT-1:0]                 correct_cnt_i,
    input  wire logic [`DCORE_NCNT-1:0]                 total_cnt_i,
    input  wire logic [`DCORE_NPI-1:0]                  pi_ctl_i
);

    import dcore_pkg::*;

    logic                 access;
    logic                 addr_ok;
    logic                 addr_rw;
    logic                 wr_en;
    logic [`DCORE_DW-1:0] rdata;

    assign access = psel_i && penable_i;

    // Decode and read mux
    always_comb begin
        addr_ok = 1'b1;
        addr_rw = 1'b0;
        rdata   = '0;
        case (paddr_i)
            REG_CTRL: begin
                addr_rw    = 1'b1;
                rdata[1:0] = prbs_mode_o;
                rdata[2]   = pi_ext_sel_o;
            end
            REG_SEED: begin
                addr_rw                    = 1'b1;
                rdata[`DCORE_NPRBS-1:0]    = prbs_seed_o;
            end
            REG_OFFSET: begin
                addr_rw                             = 1'b1;
                rdata[`DCORE_NTI*`DCORE_NADC-1:0]   = lane_offset_o;
            end
            REG_PI_EXT: begin
                addr_rw                  = 1'b1;
                rdata[`DCORE_NPI-1:0]    = pi_ext_o;
            end
            REG_PI_OFS: begin
                addr_rw                  = 1'b1;
                rdata[`DCORE_NPI-1:0]    = pi_ofs_o;
            end
            REG_GAIN: begin
                addr_rw    = 1'b1;
                rdata[7:0] = {ki_shift_o, kp_shift_o};
            end
            REG_SAMPLE:  rdata[`DCORE_NTI*`DCORE_NADC-1:0] = samples_i;
            REG_CORRECT: rdata = correct_cnt_i;
            REG_TOTAL:   rdata = total_cnt_i;
            REG_PI_CODE: rdata[`DCORE_NPI-1:0] = pi_ctl_i;
            default:     addr_ok = 1'b0;
        endcase
    end

    // No wait states
    assign pready_o  = 1'b1;
    assign wr_en     = access && pwrite_i && addr_rw;
    assign pslverr_o = access && (pwrite_i ? !addr_rw : !addr_ok);
    assign prdata_o  = (access && !pwrite_i && addr_ok) ? rdata : '0;

    always_ff @(posedge clk_adc or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lane_offset_o <= '0;
            prbs_mode_o   <= PRBS_HOLD;
            prbs_seed_o   <= '0;
            pi_ext_sel_o  <= 1'b0;
            pi_ext_o      <= '0;
            pi_ofs_o      <= '0;
            kp_shift_o    <= '0;
            ki_shift_o    <= '0;
        end else if (wr_en) begin
            case (paddr_i)
                REG_CTRL: begin
                    prbs_mode_o  <= prbs_mode_e'(pwdata_i[1:0]);
                    pi_ext_sel_o <= pwdata_i[2];
                end
                REG_SEED:   prbs_seed_o   <= pwdata_i[`DCORE_NPRBS-1:0];
                REG_OFFSET: lane_offset_o <= pwdata_i[`DCORE_NTI*`DCORE_NADC-1:0];
                REG_PI_EXT: pi_ext_o      <= pwdata_i[`DCORE_NPI-1:0];
                REG_PI_OFS: pi_ofs_o      <= pwdata_i[`DCORE_NPI-1:0];
                REG_GAIN: begin
                    kp_shift_o <= pwdata_i[3:0];
                    ki_shift_o <= pwdata_i[7:4];
                end
                default: ;
            endcase
        end
    end

    a_penable_in_sel: assert property (@(posedge clk_adc) disable iff (!arst_n_i)
        penable_i |-> psel_i);

endmodule

`default_nettype wire

//--- design/digital_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcore_consts.svh"

module digital_core (
    input  wire logic                                   clk_adc,
    input  wire logic                                   arst_n_i,
    input  wire logic [`DCORE_NTI-1:0][`DCORE_NADC-2:0] adc_mag_i,
    input  wire logic [`DCORE_NTI-1:0]                  adc_sign_i,
    input  wire logic [`DCORE_AW-1:0]                   paddr_i,
    input  wire logic                                   psel_i,
    input  wire logic                                   penable_i,
    input  wire logic                                   pwrite_i,
    input  wire logic [`DCORE_DW-1:0]                   pwdata_i,
    output wire logic [`DCORE_DW-1:0]                   prdata_o,
    output wire logic                                   pready_o,
    output wire logic                                   pslverr_o,
    output wire logic [`DCORE_NPI-1:0]                  pi_ctl_o
);

    import dcore_pkg::*;

    wire logic [`DCORE_NTI-1:0][`DCORE_NADC-1:0] samples;
    wire logic [`DCORE_NTI-1:0][`DCORE_NADC-1:0] lane_offset;
    wire prbs_mode_e                             prbs_mode;
    wire logic [`DCORE_NPRBS-1:0]                prbs_seed;
    wire logic                                   pi_ext_sel;
    wire logic [`DCORE_NPI-1:0]                  pi_ext;
    wire logic [`DCORE_NPI-1:0]                  pi_ofs;
    wire logic [3:0]                             kp_shift;
    wire logic [3:0]                             ki_shift;
    wire logic [`DCORE_NCNT-1:0]                 correct_cnt;
    wire logic [`DCORE_NCNT-1:0]                 total_cnt;
    wire logic [`DCORE_NPI-1:0]                  pi_ctl;

    assign pi_ctl_o = pi_ctl;

    // ADC input side
    adc_unfold u_unfold (
        .clk_adc       (clk_adc),
        .arst_n_i      (arst_n_i),
        .adc_mag_i     (adc_mag_i),
        .adc_sign_i    (adc_sign_i),
        .lane_offset_i (lane_offset),
        .samples_o     (samples)
    );

    mm_cdr u_cdr (
        .clk_adc      (clk_adc),
        .arst_n_i     (arst_n_i),
        .samples_i    (samples),
        .pi_ext_sel_i (pi_ext_sel),
        .pi_ext_i     (pi_ext),
        .pi_ofs_i     (pi_ofs),
        .kp_shift_i   (kp_shift),
        .ki_shift_i   (ki_shift),
        .pi_ctl_o     (pi_ctl)
    );

    prbs_checker u_prbs (
        .clk_adc       (clk_adc),
        .arst_n_i      (arst_n_i),
        .samples_i     (samples),
        .mode_i        (prbs_mode),
        .seed_i        (prbs_seed),
        .correct_cnt_o (correct_cnt),
        .total_cnt_o   (total_cnt)
    );

    // Register block
    dcore_regs u_regs (
        .clk_adc       (clk_adc),
        .arst_n_i      (arst_n_i),
        .paddr_i       (paddr_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .lane_offset_o (lane_offset),
        .prbs_mode_o   (prbs_mode),
        .prbs_seed_o   (prbs_seed),
        .pi_ext_sel_o  (pi_ext_sel),
        .pi_ext_o      (pi_ext),
        .pi_ofs_o      (pi_ofs),
        .kp_shift_o    (kp_shift),
        .ki_shift_o    (ki_shift),
        .samples_i     (samples),
        .correct_cnt_i (correct_cnt),
        .total_cnt_i   (total_cnt),
        .pi_ctl_i      (pi_ctl)
    );

endmodule

`default_nettype wire

//--- tests/tb_dcore_checks.svh
`ifndef TB_DCORE_CHECKS_SVH
`define TB_DCORE_CHECKS_SVH

task automatic check_word(input logic [`DCORE_DW-1:0] got, input logic [`DCORE_DW-1:0] exp,
                          input string what);
    if (got !== exp) begin
        $display("[ERROR] %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
        err_count++;
    end
endtask

task automatic check_pi(input logic [`DCORE_NPI-1:0] got, input logic [`DCORE_NPI-1:0] exp,
                        input string what);
    if (got !== exp) begin
        $display("[ERROR] %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
        err_count++;
    end
endtask

task automatic check_counts(input logic [`DCORE_NCNT-1:0] correct,
                            input logic [`DCORE_NCNT-1:0] total,
                            input logic [`DCORE_NCNT-1:0] exp_total,
                            input logic [`DCORE_NCNT-1:0] exp_diff);
    if (total !== exp_total || (total - correct) !== exp_diff) begin
        $display("[ERROR] %0t ns: counters correct %0d total %0d, expected total %0d diff %0d",
                 $time, correct, total, exp_total, exp_diff);
        err_count++;
    end
endtask

// PRBS7 x^7+x^6+1, lane 0 is the first bit
function automatic logic [`DCORE_NTI-1:0] prbs_word(input logic [`DCORE_NPRBS-1:0] state);
    logic [`DCORE_NTI-1:0]   bits;
    logic [`DCORE_NPRBS-1:0] s;
    s = state;
    for (int k = 0; k < `DCORE_NTI; k++) begin
        bits[k] = s[`DCORE_NPRBS-1] ^ s[`DCORE_NPRBS-2];
        s = {s[`DCORE_NPRBS-2:0], bits[k]};
    end
    return bits;
endfunction

function automatic logic [`DCORE_NPRBS-1:0] prbs_adv(input logic [`DCORE_NPRBS-1:0] state);
    logic [`DCORE_NPRBS-1:0] s;
    s = state;
    for (int k = 0; k < `DCORE_NTI; k++) begin
        s = {s[`DCORE_NPRBS-2:0], s[`DCORE_NPRBS-1] ^ s[`DCORE_NPRBS-2]};
    end
    return s;
endfunction

// Signed magnitude minus lane offset, clamped to 8 bits
function automatic logic [`DCORE_NADC-1:0] expected_sample(input logic [`DCORE_NADC-2:0] mag,
                                                           input logic sign,
                                                           input logic [`DCORE_NADC-1:0] ofs);
    int v;
    int o;
    o = $signed(ofs);
    v = sign ? int'(mag) : -int'(mag);
    v = v - o;
    if (v > 127) begin
        v = 127;
    end else if (v < -128) begin
        v = -128;
    end
    return v[`DCORE_NADC-1:0];
endfunction

`endif

//--- tests/tb_digital_core.sv
`timescale 1ns/1ps
`include "dcore_consts.svh"

module tb_digital_core;

    import dcore_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_OPS    = 64;

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_HOLD, OP_STREAM, OP_CHK_SAMPLE, OP_CHK_CNT, OP_CHK_PI, OP_PI_STABLE
    } op_kind_e;

    typedef struct {
        op_kind_e             kind;
        logic [`DCORE_AW-1:0] addr;
        logic [`DCORE_DW-1:0] data;
        logic [`DCORE_DW-1:0] expect_val;
        logic                 expect_err;
        int                   cycles;
    } op_t;

    logic                                   clk_adc;
    logic                                   arst_n_i;
    logic [`DCORE_NTI-1:0][`DCORE_NADC-2:0] adc_mag_i;
    logic [`DCORE_NTI-1:0]                  adc_sign_i;
    logic [`DCORE_AW-1:0]                   paddr_i;
    logic                                   psel_i;
    logic                                   penable_i;
    logic                                   pwrite_i;
    logic [`DCORE_DW-1:0]                   pwdata_i;
    logic [`DCORE_DW-1:0]                   prdata_o;
    logic                                   pready_o;
    logic                                   pslverr_o;
    logic [`DCORE_NPI-1:0]                  pi_ctl_o;

    int                                     err_count;
    integer                                 seed;
    op_t                                    ops [MAX_OPS];
    int                                     n_ops;
    logic [`DCORE_NTI-1:0][`DCORE_NADC-2:0] held_mag;
    logic [`DCORE_NTI-1:0]                  held_sign;
    logic [`DCORE_NTI-1:0][`DCORE_NADC-1:0] cur_offset;
    logic [`DCORE_NPRBS-1:0]                cur_seed;
    logic                                   stream_on;
    logic [`DCORE_NPRBS-1:0]                ref_state;
    int                                     stream_idx;
    int                                     inject_n;

    `include "tb_dcore_checks.svh"

    digital_core uut (
        .clk_adc    (clk_adc),
        .arst_n_i   (arst_n_i),
        .adc_mag_i  (adc_mag_i),
        .adc_sign_i (adc_sign_i),
        .paddr_i    (paddr_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .pi_ctl_o   (pi_ctl_o)
    );

    always #(CLK_PERIOD/2) clk_adc = ~clk_adc;

    // PRBS source, a sign bit of 1 decodes as a received 1
    always @(negedge clk_adc) begin : stream_drive
        logic [`DCORE_NTI-1:0] word;
        if (stream_on) begin
            word      = prbs_word(ref_state);
            ref_state = prbs_adv(ref_state);
            if (stream_idx >= 1 && stream_idx <= inject_n) begin
                word[stream_idx % `DCORE_NTI] = ~word[stream_idx % `DCORE_NTI];
            end
            adc_sign_i = word;
            adc_mag_i  = {`DCORE_NTI{7'd40}};
            stream_idx++;
        end
    end

    task automatic apb_access(input logic wr, input logic [`DCORE_AW-1:0] addr,
                              input logic [`DCORE_DW-1:0] wdata,
                              output logic [`DCORE_DW-1:0] rdata, output logic err);
        int waits;
        @(negedge clk_adc);
        paddr_i   = addr;
        pwrite_i  = wr;
        pwdata_i  = wdata;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        @(negedge clk_adc);
        penable_i = 1'b1;
        #(CLK_PERIOD/4);
        waits = 0;
        while (pready_o !== 1'b1 && waits < 16) begin
            @(negedge clk_adc);
            #(CLK_PERIOD/4);
            waits++;
        end
        if (pready_o !== 1'b1) begin
            $display("APB slave never raised pready in the access phase at address 0x%0h", addr);
            err_count++;
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(negedge clk_adc);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic add_op(input op_kind_e kind, input logic [`DCORE_AW-1:0] addr,
                          input logic [`DCORE_DW-1:0] data, input logic [`DCORE_DW-1:0] exp,
                          input logic exp_err, input int cycles);
        ops[n_ops] = '{kind, addr, data, exp, exp_err, cycles};
        n_ops++;
    endtask

    function automatic int op_cost(input op_t op);
        case (op.kind)
            OP_HOLD:      return op.cycles + 1;
            OP_STREAM:    return op.cycles + 12;
            OP_CHK_CNT:   return 8;
            OP_PI_STABLE: return op.cycles + 5;
            default:      return 5;
        endcase
    endfunction

    task automatic build_table();
        n_ops = 0;
        // Reset values
        add_op(OP_CHK_PI, 0, 0, 0, 0, 0);
        add_op(OP_READ, REG_CTRL, 0, 0, 0, 0);
        add_op(OP_READ, REG_SEED, 0, 0, 0, 0);
        add_op(OP_READ, REG_OFFSET, 0, 0, 0, 0);
        add_op(OP_READ, REG_PI_EXT, 0, 0, 0, 0);
        add_op(OP_READ, REG_PI_OFS, 0, 0, 0, 0);
        add_op(OP_READ, REG_GAIN, 0, 0, 0, 0);
        add_op(OP_READ, REG_SAMPLE, 0, 0, 0, 0);
        add_op(OP_READ, REG_CORRECT, 0, 0, 0, 0);
        add_op(OP_READ, REG_TOTAL, 0, 0, 0, 0);
        add_op(OP_READ, REG_PI_CODE, 0, 0, 0, 0);
        // Unfolding, with offsets that force both rails
        add_op(OP_WRITE, REG_OFFSET, 32'hF010_807F, 0, 0, 0);
        add_op(OP_HOLD, 0, 32'h0001_0000, 0, 0, 4);
        add_op(OP_CHK_SAMPLE, 0, 0, 0, 0, 0);
        add_op(OP_HOLD, 0, 32'h0001_0000, 0, 0, 4);
        add_op(OP_CHK_SAMPLE, 0, 0, 0, 0, 0);
        add_op(OP_WRITE, REG_OFFSET, 32'h00FF_0102, 0, 0, 0);
        add_op(OP_HOLD, 0, 32'h0001_0000, 0, 0, 4);
        add_op(OP_CHK_SAMPLE, 0, 0, 0, 0, 0);
        add_op(OP_WRITE, REG_GAIN, 32'h32, 0, 0, 0);
        add_op(OP_READ, REG_GAIN, 0, 32'h32, 0, 0);
        // PRBS runs, N+3 checker cycles per run
        add_op(OP_WRITE, REG_OFFSET, 0, 0, 0, 0);
        add_op(OP_WRITE, REG_SEED, 32'h5A, 0, 0, 0);
        add_op(OP_READ, REG_SEED, 0, 32'h5A, 0, 0);
        add_op(OP_WRITE, REG_CTRL, PRBS_LOAD, 0, 0, 0);
        add_op(OP_STREAM, 0, 0, 0, 0, 40);
        add_op(OP_CHK_CNT, 0, 0, 172, 0, 0);
        add_op(OP_WRITE, REG_CTRL, PRBS_LOAD, 0, 0, 0);
        add_op(OP_STREAM, 0, 5, 0, 0, 60);
        add_op(OP_CHK_CNT, 0, 5, 252, 0, 0);
        // PI override, then loop mode with a flat input
        add_op(OP_WRITE, REG_PI_EXT, 32'h1A5, 0, 0, 0);
        add_op(OP_WRITE, REG_PI_OFS, 32'h0F0, 0, 0, 0);
        add_op(OP_WRITE, REG_CTRL, 32'h4, 0, 0, 0);
        add_op(OP_HOLD, 0, 32'h0000_0121, 0, 0, 6);
        add_op(OP_CHK_PI, 0, 0, 32'h095, 0, 0);
        add_op(OP_WRITE, REG_CTRL, 32'h0, 0, 0, 0);
        add_op(OP_HOLD, 0, 32'h0000_0121, 0, 0, 6);
        add_op(OP_PI_STABLE, 0, 0, 0, 0, 8);
        // APB error responses
        add_op(OP_WRITE, REG_TOTAL, 32'hFFFF, 0, 1, 0);
        add_op(OP_READ, REG_TOTAL, 0, 252, 0, 0);
        add_op(OP_WRITE, 8'h30, 32'h1234, 0, 1, 0);
        add_op(OP_READ, 8'h30, 0, 0, 1, 0);
        add_op(OP_READ, REG_CTRL, 0, 0, 0, 0);
        add_op(OP_READ, REG_PI_EXT, 0, 32'h1A5, 0, 0);
    endtask

    task automatic run_op(input op_t op);
        logic [`DCORE_DW-1:0]  rd;
        logic [`DCORE_DW-1:0]  rd2;
        logic                  err;
        logic [`DCORE_DW-1:0]  exp_word;
        logic [`DCORE_NPI-1:0] pi_cap;
        logic [31:0]           rnd;
        case (op.kind)
            OP_WRITE: begin
                apb_access(1'b1, op.addr, op.data, rd, err);
                check_word({{(`DCORE_DW-1){1'b0}}, err}, {{(`DCORE_DW-1){1'b0}}, op.expect_err},
                           "pslverr on write");
                if (!op.expect_err && op.addr == REG_OFFSET) cur_offset = op.data;
                if (!op.expect_err && op.addr == REG_SEED) cur_seed = op.data[`DCORE_NPRBS-1:0];
            end
            OP_READ: begin
                apb_access(1'b0, op.addr, '0, rd, err);
                check_word({{(`DCORE_DW-1){1'b0}}, err}, {{(`DCORE_DW-1){1'b0}}, op.expect_err},
                           "pslverr on read");
                if (!op.expect_err) check_word(rd, op.expect_val, "register readback");
            end
            OP_HOLD: begin
                @(negedge clk_adc);
                for (int k = 0; k < `DCORE_NTI; k++) begin
                    rnd = $random(seed);
                    held_mag[k]  = op.data[16] ? rnd[`DCORE_NADC-2:0] : op.data[`DCORE_NADC-2:0];
                    held_sign[k] = op.data[16] ? rnd[8] : op.data[8];
                end
                adc_mag_i  = held_mag;
                adc_sign_i = held_sign;
                repeat (op.cycles - 1) @(negedge clk_adc);
            end
            OP_STREAM: begin
                @(posedge clk_adc);
                ref_state  = cur_seed;
                stream_idx = 0;
                inject_n   = op.data;
                stream_on  = 1'b1;
                apb_access(1'b1, REG_CTRL, PRBS_RUN, rd, err);
                repeat (op.cycles) @(negedge clk_adc);
                apb_access(1'b1, REG_CTRL, PRBS_HOLD, rd, err);
                repeat (4) @(negedge clk_adc);
                @(posedge clk_adc);
                stream_on = 1'b0;
            end
            OP_CHK_SAMPLE: begin
                for (int k = 0; k < `DCORE_NTI; k++) begin
                    exp_word[k*`DCORE_NADC +: `DCORE_NADC] =
                        expected_sample(held_mag[k], held_sign[k], cur_offset[k]);
                end
                apb_access(1'b0, REG_SAMPLE, '0, rd, err);
                check_word(rd, exp_word, "REG_SAMPLE");
            end
            OP_CHK_CNT: begin
                apb_access(1'b0, REG_CORRECT, '0, rd, err);
                apb_access(1'b0, REG_TOTAL, '0, rd2, err);
                check_counts(rd, rd2, op.expect_val, op.data);
            end
            OP_CHK_PI: begin
                @(negedge clk_adc);
                #(CLK_PERIOD/4);
                check_pi(pi_ctl_o, op.expect_val[`DCORE_NPI-1:0], "pi_ctl_o");
                apb_access(1'b0, REG_PI_CODE, '0, rd, err);
                check_pi(rd[`DCORE_NPI-1:0], op.expect_val[`DCORE_NPI-1:0], "REG_PI_CODE");
            end
            default: begin
                // Flat input gives a zero detector sum, so the code must not move
                @(negedge clk_adc);
                #(CLK_PERIOD/4);
                pi_cap = pi_ctl_o;
                repeat (op.cycles) @(negedge clk_adc);
                #(CLK_PERIOD/4);
                check_pi(pi_ctl_o, pi_cap, "pi_ctl_o in loop mode");
                apb_access(1'b0, REG_PI_CODE, '0, rd, err);
                check_pi(rd[`DCORE_NPI-1:0], pi_cap, "REG_PI_CODE in loop mode");
            end
        endcase
    endtask

    initial begin
        clk_adc    = 1'b0;
        arst_n_i   = 1'b0;
        adc_mag_i  = '0;
        adc_sign_i = '0;
        paddr_i    = '0;
        psel_i     = 1'b0;
        penable_i  = 1'b0;
        pwrite_i   = 1'b0;
        pwdata_i   = '0;
        err_count  = 0;
        seed       = 17055;
        held_mag   = '0;
        held_sign  = '0;
        cur_offset = '0;
        cur_seed   = '0;
        stream_on  = 1'b0;
        ref_state  = '0;
        stream_idx = 0;
        inject_n   = 0;
        build_table();
        repeat (10) @(posedge clk_adc);
        @(negedge clk_adc);
        arst_n_i = 1'b1;
        for (int i = 0; i < n_ops; i++) begin
            run_op(ops[i]);
        end
        $display("Checks finished with %0d error(s)", err_count);
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int budget;
        #1;
        budget = 10 + 200;
        for (int i = 0; i < n_ops; i++) begin
            budget += op_cost(ops[i]);
        end
        #(budget * CLK_PERIOD);
        $display("Timeout: the test sequence did not finish within %0d cycles", budget);
        $display("sim failed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+design
+incdir+tests
design/dcore_pkg.sv
design/adc_unfold.sv
design/mm_cdr.sv
design/prbs_checker.sv
design/dcore_regs.sv
design/digital_core.sv
tests/tb_digital_core.sv

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_digital_core \
    -o sim_tb && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "^sim passed$" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
